// ==== softmax_fmt_pkg.sv ====
// Signed Q16.16 element format shared by the datapath
// Sums hold n elements of at most 1.0 each, so they never go negative
package softmax_fmt_pkg;

    localparam int width      = 32;  // Element width
    localparam int frac_width = 16;  // Fractional bits

    // One element, lane 0 sits in the most significant slot of a tile
    typedef logic signed [width-1:0] elem_t;

    localparam elem_t one_q    = elem_t'(1) <<< frac_width;   // 1.0
    localparam elem_t min_elem = {1'b1, {(width-1){1'b0}}};  // Most negative value

    // Width of an unsigned sum of n elements in [0, 1.0]
    function automatic int sum_width(input int n);
        return width + $clog2(n + 1);
    endfunction

    // Tiles needed for n elements, last tile may be partial
    function automatic int num_tiles(input int n, input int t);
        return (n + t - 1) / t;
    endfunction

endpackage

// ==== softmax_ctrl_pkg.sv ====
// Controller state encoding and the pass select seen by the exponent unit
package softmax_ctrl_pkg;

    // Passes of one run, in order
    typedef enum logic [2:0] {
        s_idle,
        s_load,    // Store tiles, track the maximum
        s_sum,     // Read back, accumulate 2^(x - max)
        s_log,     // Register log2 of the sum
        s_output,  // Read back, emit normalized tiles
        s_done
    } state_t;

    // Which offset the exponent unit applies
    typedef enum logic {
        sum_pass,  // x - max
        out_pass   // x - max - log2(sum)
    } pass_t;

endpackage

// ==== softmax_ctrl.sv ====
// Pass sequencer; one tile is read per cycle, read data lands one cycle after its address
// Input tiles are taken only in load, there is no back-pressure on either stream
`timescale 1ns/100ps

module softmax_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    tile_in_valid,
    input  logic                    last_tile,
    output logic                    cnt_clear,
    output logic                    cnt_step,
    output logic                    wr_en,
    output logic                    max_en,
    output logic                    acc_clear,
    output logic                    acc_en,
    output logic                    log_load,
    output logic                    out_en,
    output logic                    done,
    output softmax_ctrl_pkg::pass_t pass
);

    softmax_ctrl_pkg::state_t state, state_nx;

    logic accept;  // Input tile written this cycle
    logic issue;   // Read address issued this cycle
    logic rd_q;    // Read data valid this cycle
    logic last_q;  // Read data of the last tile valid this cycle

    assign accept = (state == softmax_ctrl_pkg::s_load) && tile_in_valid;

    // Stop issuing once the last address has gone out, the pass then drains one cycle
    assign issue = ((state == softmax_ctrl_pkg::s_sum) || (state == softmax_ctrl_pkg::s_output))
                   && !last_q;

    assign cnt_clear = start && ((state == softmax_ctrl_pkg::s_idle) ||
                                 (state == softmax_ctrl_pkg::s_done));
    assign cnt_step  = accept || issue;
    assign wr_en     = accept;
    assign max_en    = accept;
    assign acc_clear = accept && last_tile;  // Sum starts fresh on the next cycle
    assign acc_en    = rd_q && (state == softmax_ctrl_pkg::s_sum);
    assign log_load  = (state == softmax_ctrl_pkg::s_log);
    assign out_en    = rd_q && (state == softmax_ctrl_pkg::s_output);
    assign pass      = (state == softmax_ctrl_pkg::s_output) ? softmax_ctrl_pkg::out_pass
                                                             : softmax_ctrl_pkg::sum_pass;

    always_comb begin
        state_nx = state;
        case (state)
            softmax_ctrl_pkg::s_idle:   if (start) state_nx = softmax_ctrl_pkg::s_load;
            softmax_ctrl_pkg::s_load:   if (accept && last_tile) state_nx = softmax_ctrl_pkg::s_sum;
            softmax_ctrl_pkg::s_sum:    if (last_q) state_nx = softmax_ctrl_pkg::s_log;
            softmax_ctrl_pkg::s_log:    state_nx = softmax_ctrl_pkg::s_output;
            softmax_ctrl_pkg::s_output: if (last_q) state_nx = softmax_ctrl_pkg::s_done;
            softmax_ctrl_pkg::s_done: begin
                state_nx = start ? softmax_ctrl_pkg::s_load : softmax_ctrl_pkg::s_idle;
            end
            default:                    state_nx = softmax_ctrl_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= softmax_ctrl_pkg::s_idle;
            rd_q   <= 1'b0;
            last_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            state  <= state_nx;
            rd_q   <= issue;
            last_q <= issue && last_tile;
            done   <= (state == softmax_ctrl_pkg::s_done);  // Lands after the last tile_out_valid
        end
    end

    // Runs are at least several cycles long, so two done pulses can never touch
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

endmodule

// ==== tile_counter.sv ====
// Tile index within a pass; wraps to zero after the last tile so every pass starts at 0
`timescale 1ns/100ps

module tile_counter #(
    parameter int TOTAL_ELEMENTS = 20,
    parameter int TILE_SIZE      = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cnt_clear,
    input  logic                                    cnt_step,
    output logic [$clog2(softmax_fmt_pkg::num_tiles(TOTAL_ELEMENTS, TILE_SIZE) + 1)-1:0] addr,
    output logic [$clog2(TILE_SIZE + 1)-1:0]        valid_lanes,
    output logic                                    last_tile
);

    localparam int n_tiles    = softmax_fmt_pkg::num_tiles(TOTAL_ELEMENTS, TILE_SIZE);
    localparam int addr_w     = $clog2(n_tiles + 1);
    localparam int lane_w     = $clog2(TILE_SIZE + 1);
    localparam int last_lanes = TOTAL_ELEMENTS - (n_tiles - 1) * TILE_SIZE;  // 1..TILE_SIZE

    assign last_tile   = (addr == addr_w'(n_tiles - 1));
    assign valid_lanes = last_tile ? lane_w'(last_lanes) : lane_w'(TILE_SIZE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (cnt_clear) begin
            addr <= '0;
        end else if (cnt_step) begin
            if (last_tile) begin
                addr <= '0;  // Wrap, next pass begins at tile 0
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    // The buffer only has n_tiles words
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        addr < addr_w'(n_tiles));

endmodule

// ==== tile_buffer.sv ====
// One write port, one read port; read data appears the cycle after rd_addr
`timescale 1ns/100ps

module tile_buffer #(
    parameter int TOTAL_ELEMENTS = 20,
    parameter int TILE_SIZE      = 8
) (
    input  logic                                          clk,
    input  logic                                          wr_en,
    input  logic [$clog2(softmax_fmt_pkg::num_tiles(TOTAL_ELEMENTS, TILE_SIZE) + 1)-1:0] wr_addr,
    input  logic [$clog2(softmax_fmt_pkg::num_tiles(TOTAL_ELEMENTS, TILE_SIZE) + 1)-1:0] rd_addr,
    input  softmax_fmt_pkg::elem_t [0:TILE_SIZE-1]        wr_data,
    output softmax_fmt_pkg::elem_t [0:TILE_SIZE-1]        rd_data
);

    localparam int n_tiles = softmax_fmt_pkg::num_tiles(TOTAL_ELEMENTS, TILE_SIZE);

    softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] mem [n_tiles];  // One word per tile

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // Read every cycle
    end

endmodule

// ==== max_tracker.sv ====
// Running maximum over the valid lanes of each loaded tile
// Padding lanes of the last tile never take part
`timescale 1ns/100ps

module max_tracker #(
    parameter int TILE_SIZE = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   max_en,
    input  logic                                   clear,
    input  softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] tile_in,
    input  logic [$clog2(TILE_SIZE + 1)-1:0]       valid_lanes,
    output softmax_fmt_pkg::elem_t                 max_val
);

    localparam int lane_w = $clog2(TILE_SIZE + 1);

    softmax_fmt_pkg::elem_t tile_max;  // Max of running value and this tile

    always_comb begin
        tile_max = max_val;
        for (int i = 0; i < TILE_SIZE; i++) begin
            if ((lane_w'(i) < valid_lanes) && (tile_in[i] > tile_max)) begin
                tile_max = tile_in[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            max_val <= softmax_fmt_pkg::min_elem;
        end else if (clear) begin
            max_val <= softmax_fmt_pkg::min_elem;  // New run
        end else if (max_en) begin
            max_val <= tile_max;
        end
    end

endmodule

// ==== pow2_vec.sv ====
// Per-lane 2^t with 2^f approximated as 1 + f; t is formed with two guard bits so it never wraps
// Lanes at or past the tile's valid count read as zero
`timescale 1ns/100ps

module pow2_vec #(
    parameter int TILE_SIZE = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] rd_data,
    input  softmax_fmt_pkg::elem_t                 max_val,
    input  softmax_fmt_pkg::elem_t                 log_val,
    input  softmax_ctrl_pkg::pass_t                pass,
    input  logic [$clog2(TILE_SIZE + 1)-1:0]       valid_lanes,
    input  logic                                   out_en,
    output softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] exp_tile,
    output softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] tile_out,
    output logic                                   tile_out_valid
);

    localparam int w      = softmax_fmt_pkg::width;
    localparam int fw     = softmax_fmt_pkg::frac_width;
    localparam int lane_w = $clog2(TILE_SIZE + 1);

    logic [lane_w-1:0]      lanes_q;   // Lane count aligned with rd_data
    softmax_fmt_pkg::elem_t log_term;

    // 2^(x - m - l) = (1 + frac) >> -floor(t)
    function automatic softmax_fmt_pkg::elem_t pow2(input softmax_fmt_pkg::elem_t x,
                                                    input softmax_fmt_pkg::elem_t m,
                                                    input softmax_fmt_pkg::elem_t l);
        logic signed [w+1:0] t;
        logic signed [w+1:0] ip;
        logic [fw:0]         mant;
        t    = x - m - l;
        ip   = t >>> fw;               // floor(t)
        mant = {1'b1, t[fw-1:0]};      // one_q plus the fraction
        if (ip <= -w) return '0;       // Shift of width or more
        if (ip >= 0) return softmax_fmt_pkg::elem_t'(mant);  // Only t in [0,1) on valid lanes
        return softmax_fmt_pkg::elem_t'(mant >> (-ip));
    endfunction

    assign log_term = (pass == softmax_ctrl_pkg::out_pass) ? log_val : '0;

    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            if (lane_w'(i) < lanes_q) begin
                exp_tile[i] = pow2(rd_data[i], max_val, log_term);
            end else begin
                exp_tile[i] = '0;  // Padding lane
            end
        end
    end

    always_ff @(posedge clk) begin
        lanes_q <= valid_lanes;  // Follows the address into the buffer
        if (out_en) begin
            tile_out <= exp_tile;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tile_out_valid <= 1'b0;
        end else begin
            tile_out_valid <= out_en;
        end
    end

endmodule

// ==== log2_sum.sv ====
// Sum of exponent tiles and log2 of the total, log2 m taken as m - 1 on the mantissa
// The sum must be at least 1.0 when the log is taken, which the max lane guarantees
`timescale 1ns/100ps

module log2_sum #(
    parameter int TOTAL_ELEMENTS = 20,
    parameter int TILE_SIZE      = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   acc_clear,
    input  logic                                   acc_en,
    input  logic                                   log_load,
    input  softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] exp_tile,
    output softmax_fmt_pkg::elem_t                 log_val
);

    localparam int w     = softmax_fmt_pkg::width;
    localparam int fw    = softmax_fmt_pkg::frac_width;
    localparam int sum_w = softmax_fmt_pkg::sum_width(TOTAL_ELEMENTS);

    logic [sum_w-1:0]       tile_sum;
    logic [sum_w-1:0]       sum_q;
    logic [sum_w-1:0]       norm;   // Sum with its leading one at the top bit
    int                     lead;   // Leading-one position
    softmax_fmt_pkg::elem_t log_d;

    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile_sum = tile_sum + sum_w'(unsigned'(exp_tile[i]));  // Lanes are non-negative
        end
    end

    always_comb begin
        lead = 0;
        for (int b = 0; b < sum_w; b++) begin
            if (sum_q[b]) lead = b;
        end
        norm  = sum_q << (sum_w - 1 - lead);
        // Integer part k - frac_width, fraction is the bits below the leading one
        log_d = {(w - fw)'(lead - fw), norm[sum_w-2 -: fw]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_q <= '0;
        end else if (acc_clear) begin
            sum_q <= '0;
        end else if (acc_en) begin
            sum_q <= sum_q + tile_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (log_load) begin
            log_val <= log_d;
        end
    end

    // The max lane contributes exactly 1.0, so a smaller sum means a broken sum pass
    a_sum_min: assert property (@(posedge clk) disable iff (!rst_n)
        log_load |-> (sum_q >= sum_w'(softmax_fmt_pkg::one_q)));

endmodule

// ==== softmax_top.sv ====
// Tiled base-2 softmax over TOTAL_ELEMENTS Q16.16 values, TILE_SIZE per tile
// No back-pressure, and the source sends at most the vector length per run
`timescale 1ns/100ps

module softmax_top #(
    parameter int TOTAL_ELEMENTS = 20,
    parameter int TILE_SIZE      = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] tile_in,
    input  logic                                   tile_in_valid,
    output softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] tile_out,
    output logic                                   tile_out_valid,
    output logic                                   done
);

    localparam int n_tiles = softmax_fmt_pkg::num_tiles(TOTAL_ELEMENTS, TILE_SIZE);
    localparam int addr_w  = $clog2(n_tiles + 1);
    localparam int lane_w  = $clog2(TILE_SIZE + 1);

    logic                                   cnt_clear, cnt_step, last_tile;
    logic                                   wr_en, max_en;
    logic                                   acc_clear, acc_en, log_load, out_en;
    softmax_ctrl_pkg::pass_t                pass;
    logic [addr_w-1:0]                      addr;         // Shared write and read address
    logic [lane_w-1:0]                      valid_lanes;
    softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] rd_data;
    softmax_fmt_pkg::elem_t [0:TILE_SIZE-1] exp_tile;
    softmax_fmt_pkg::elem_t                 max_val;
    softmax_fmt_pkg::elem_t                 log_val;

    softmax_ctrl i_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .tile_in_valid(tile_in_valid),
        .last_tile(last_tile), .cnt_clear(cnt_clear), .cnt_step(cnt_step), .wr_en(wr_en),
        .max_en(max_en), .acc_clear(acc_clear), .acc_en(acc_en), .log_load(log_load),
        .out_en(out_en), .done(done), .pass(pass)
    );

    tile_counter #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS), .TILE_SIZE(TILE_SIZE)) i_counter (
        .clk(clk), .rst_n(rst_n), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
        .addr(addr), .valid_lanes(valid_lanes), .last_tile(last_tile)
    );

    tile_buffer #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS), .TILE_SIZE(TILE_SIZE)) i_buffer (
        .clk(clk), .wr_en(wr_en), .wr_addr(addr), .rd_addr(addr),
        .wr_data(tile_in), .rd_data(rd_data)
    );

    max_tracker #(.TILE_SIZE(TILE_SIZE)) i_max (
        .clk(clk), .rst_n(rst_n), .max_en(max_en), .clear(cnt_clear),  // Cleared as a run starts
        .tile_in(tile_in), .valid_lanes(valid_lanes), .max_val(max_val)
    );

    pow2_vec #(.TILE_SIZE(TILE_SIZE)) i_pow2 (
        .clk(clk), .rst_n(rst_n), .rd_data(rd_data), .max_val(max_val), .log_val(log_val),
        .pass(pass), .valid_lanes(valid_lanes), .out_en(out_en), .exp_tile(exp_tile),
        .tile_out(tile_out), .tile_out_valid(tile_out_valid)
    );

    log2_sum #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS), .TILE_SIZE(TILE_SIZE)) i_log2 (
        .clk(clk), .rst_n(rst_n), .acc_clear(acc_clear), .acc_en(acc_en),
        .log_load(log_load), .exp_tile(exp_tile), .log_val(log_val)
    );

endmodule

// ==== tb_softmax_model.svh ====
// Reference base-2 softmax arithmetic in Q16.16, 2^f taken as 1 + f and log2 m as m - 1
// Included inside the testbench module
`ifndef TB_SOFTMAX_MODEL_SVH
`define TB_SOFTMAX_MODEL_SVH

// 2^t for t in Q16.16, held in 64 bits so it never wraps
function automatic int model_pow2(input longint t);
    longint frac;
    longint whole;
    frac  = t & 64'hFFFF;        // Fraction is never negative
    whole = (t - frac) / 65536;  // floor(t)
    if (whole <= -32) begin
        return 0;                // Shifted out of the element
    end
    if (whole >= 0) begin
        return int'((65536 + frac) << whole);
    end
    return int'((65536 + frac) >> (-whole));
endfunction

// log2 of an unsigned Q16.16 sum, integer part from the leading one
function automatic int model_log2(input longint s);
    int     lead;
    longint frac;
    lead = 0;
    while (lead < 62 && (s >> (lead + 1)) != 0) begin
        lead++;
    end
    if (lead >= 16) begin
        frac = (s >> (lead - 16)) & 64'hFFFF;  // 16 bits below the leading one
    end else begin
        frac = (s << (16 - lead)) & 64'hFFFF;
    end
    return ((lead - 16) <<< 16) | int'(frac);
endfunction

// Element positions past the vector length are padding and read as zero
function automatic bit model_lane_used(input int index, input int total);
    return index < total;
endfunction

`endif

// ==== tb_softmax.sv ====
// Testbench for softmax_top; five stored vectors run in a loop against a base-2 reference model
// Inputs change on the falling clock edge and outputs are sampled there as well
`timescale 1ns/100ps

module tb_softmax;

    localparam int total_elems = 20;
    localparam int tile_size   = 8;
    localparam int n_tiles     = (total_elems + tile_size - 1) / tile_size;
    localparam int n_vecs      = 5;
    localparam int run_limit   = 100;  // Cycles allowed from the last input tile to done

    logic                                   clk;
    logic                                   rst_n;
    logic                                   start;
    softmax_fmt_pkg::elem_t [0:tile_size-1] tile_in;
    logic                                   tile_in_valid;
    softmax_fmt_pkg::elem_t [0:tile_size-1] tile_out;
    logic                                   tile_out_valid;
    logic                                   done;

    // Kind 0 random, 1 all equal to vec_arg, 2 random with element vec_arg at 100.0
    int vec_kind   [n_vecs] = '{0, 1, 2, 0, 0};
    int vec_arg    [n_vecs] = '{0, 32'h03E8_0000, 13, 0, 0};
    int pre_stray  [n_vecs] = '{0, 2, 0, 4, 0};  // Valid tiles driven before start
    int tile_gap   [n_vecs] = '{0, 0, 1, 3, 0};  // Idle cycles between input tiles
    int hold_start [n_vecs] = '{0, 0, 0, 1, 0};  // Start stays high into the next run

    int vec      [total_elems];
    int expect_q [n_tiles*tile_size];
    int seed;
    int errors;
    int runs_done;

    `include "tb_softmax_model.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    softmax_top #(.TOTAL_ELEMENTS(total_elems), .TILE_SIZE(tile_size)) i_softmax_top (
        .clk(clk), .rst_n(rst_n), .start(start), .tile_in(tile_in),
        .tile_in_valid(tile_in_valid), .tile_out(tile_out),
        .tile_out_valid(tile_out_valid), .done(done)
    );

    task automatic fill_vector(input int v);
        for (int i = 0; i < total_elems; i++) begin
            if (vec_kind[v] == 1) begin
                vec[i] = vec_arg[v];
            end else begin
                vec[i] = $random(seed) % 524288;  // Within +-8.0
            end
        end
        if (vec_kind[v] == 2) begin
            vec[vec_arg[v]] = 32'h0064_0000;  // 100.0 outweighs every other lane
        end
    endtask

    task automatic build_expected();
        int     max_v;
        longint sum;
        int     log_v;
        max_v = vec[0];
        for (int i = 1; i < total_elems; i++) begin
            if (vec[i] > max_v) max_v = vec[i];
        end
        sum = 0;
        for (int i = 0; i < total_elems; i++) begin
            sum += model_pow2(longint'(vec[i]) - max_v);
        end
        log_v = model_log2(sum);
        for (int i = 0; i < n_tiles*tile_size; i++) begin
            expect_q[i] = 0;
            if (model_lane_used(i, total_elems)) begin
                expect_q[i] = model_pow2(longint'(vec[i]) - max_v - log_v);
            end
        end
    endtask

    task automatic drive_tile(input int t);
        for (int l = 0; l < tile_size; l++) begin
            if (t*tile_size + l < total_elems) begin
                tile_in[l] = vec[t*tile_size + l];
            end else begin
                tile_in[l] = $random(seed);  // Padding garbage
            end
        end
        tile_in_valid = 1'b1;
    endtask

    task automatic drive_stray_tile();
        for (int l = 0; l < tile_size; l++) tile_in[l] = $random(seed);
        tile_in_valid = 1'b1;
    endtask

    task automatic check_tile(input int t);
        for (int l = 0; l < tile_size; l++) begin
            if (tile_out[l] !== expect_q[t*tile_size + l]) begin
                errors++;
                $display("mismatch tile_out[%0d] lane %0d: got %h expected %h",
                         t, l, tile_out[l], expect_q[t*tile_size + l]);
            end
        end
    endtask

    task automatic check_quiet();
        if (tile_out_valid !== 1'b0) begin
            errors++;
            $display("mismatch tile_out_valid after reset: got %h expected 0", tile_out_valid);
        end
        if (done !== 1'b0) begin
            errors++;
            $display("mismatch done after reset: got %h expected 0", done);
        end
    endtask

    task automatic run_vector(input int v);
        int got;
        int cyc;
        bit seen_done;
        fill_vector(v);
        build_expected();
        for (int i = 0; i < pre_stray[v]; i++) begin
            @(negedge clk);
            drive_stray_tile();  // Engine is idle, tile must be dropped
        end
        if (!(v > 0 && hold_start[v-1] != 0)) begin
            @(negedge clk);
            tile_in_valid = 1'b0;
            start = 1'b1;
        end
        for (int t = 0; t < n_tiles; t++) begin
            @(negedge clk);
            start = (hold_start[v] != 0);
            drive_tile(t);
            for (int g = 0; g < tile_gap[v] && t < n_tiles - 1; g++) begin
                @(negedge clk);
                tile_in_valid = 1'b0;
            end
        end
        got = 0;
        cyc = 0;
        seen_done = 1'b0;
        while (!seen_done && cyc < run_limit) begin
            @(negedge clk);
            tile_in_valid = 1'b0;
            cyc++;
            if (tile_out_valid) begin
                if (got < n_tiles) check_tile(got);
                got++;
            end
            seen_done = done;
        end
        if (!seen_done) begin
            errors++;
            $display("vector %0d gave no done pulse within %0d cycles", v, run_limit);
        end
        if (got != n_tiles) begin
            errors++;
            $display("mismatch tile_out_valid count: got %h expected %h", got, n_tiles);
        end
        runs_done += seen_done;
    endtask

    initial begin
        int wait_cyc;
        seed          = 26;
        errors        = 0;
        runs_done     = 0;
        rst_n         = 1'b0;
        start         = 1'b0;
        tile_in       = '0;
        tile_in_valid = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        check_quiet();
        for (int v = 0; v < n_vecs; v++) run_vector(v);
        // Reset while the output stream runs must silence it
        fill_vector(0);
        @(negedge clk);
        start = 1'b1;
        for (int t = 0; t < n_tiles; t++) begin
            @(negedge clk);
            start = 1'b0;
            drive_tile(t);
        end
        wait_cyc = 0;
        @(negedge clk);
        tile_in_valid = 1'b0;
        while (tile_out_valid !== 1'b1 && wait_cyc < run_limit) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (tile_out_valid !== 1'b1) begin
            errors++;
            $display("no output tile appeared within %0d cycles before the reset", run_limit);
        end
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_quiet();
        end
        $display("checks complete: %0d errors, %0d of %0d runs ended with done",
                 errors, runs_done, n_vecs);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
softmax_fmt_pkg.sv
softmax_ctrl_pkg.sv
softmax_ctrl.sv
tile_counter.sv
tile_buffer.sv
max_tracker.sv
pow2_vec.sv
log2_sum.sv
softmax_top.sv
tb_softmax.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_softmax
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "Simulation FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
